// ==== logic/lane_bank.sv ====
// input lane bank
// steers each write to one of the lane FIFOs and reports full flags

`timescale 1ns/100ps

module lane_bank #(
  parameter int FIFO_LOG = 2
) (
  input  logic                                              CLK,
  input  logic                                              RST,
  rec_wr_if.dst                                             wr,
  input  logic [sort_cfg_pkg::NUM_LANES-1:0]                i_deq,
  output sort_rec_pkg::rec_u [sort_cfg_pkg::NUM_LANES-1:0]  o_head,
  output logic [sort_cfg_pkg::NUM_LANES-1:0]                o_head_valid
);

  logic [sort_cfg_pkg::NUM_LANES-1:0] lane_sel;   // decoded write lane
  logic [sort_cfg_pkg::NUM_LANES-1:0] lane_enq;
  logic [sort_cfg_pkg::NUM_LANES-1:0] lane_full;

  always_comb begin
    lane_sel          = '0;
    lane_sel[wr.lane] = wr.wr_en;
  end

  // writes to a full lane are dropped here
  assign lane_enq = lane_sel & ~lane_full;

  for (genvar g = 0; g < sort_cfg_pkg::NUM_LANES; g++) begin : g_lane
    lane_fifo #(
      .FIFO_LOG (FIFO_LOG)
    ) u_fifo (
      .CLK     (CLK),
      .RST     (RST),
      .i_enq   (lane_enq[g]),
      .i_deq   (i_deq[g]),
      .i_din   (wr.rec),
      .o_dout  (o_head[g]),
      .o_valid (o_head_valid[g]),
      .o_full  (lane_full[g])
    );
  end

  assign wr.full = lane_full;

endmodule

// ==== logic/lane_fifo.sv ====
// shift register FIFO for one input lane
// new records shift in at mem[0] and the head pointer tracks the oldest

`timescale 1ns/100ps

module lane_fifo #(
  parameter int FIFO_LOG = 2
) (
  input  logic               CLK,
  input  logic               RST,
  input  logic               i_enq,
  input  logic               i_deq,
  input  sort_rec_pkg::rec_u i_din,
  output sort_rec_pkg::rec_u o_dout,
  output logic               o_valid,
  output logic               o_full
);

  localparam logic [FIFO_LOG:0] DEPTH = 1 << FIFO_LOG;

  sort_rec_pkg::rec_u  mem [DEPTH];
  logic [FIFO_LOG-1:0] head;  // index of oldest entry
  logic [FIFO_LOG:0]   cnt;   // occupancy

  always_ff @(posedge CLK) begin
    if (RST) begin
      cnt  <= '0;
      head <= '1;  // wraps to 0 on first write
    end else begin
      case ({i_enq, i_deq})
        2'b10: begin
          cnt  <= cnt + 1'b1;
          head <= head + 1'b1;
        end
        2'b01: begin
          cnt  <= cnt - 1'b1;
          head <= head - 1'b1;
        end
        default: ;  // push with pop shifts the next entry under the head
      endcase
    end
  end

  // data path shifts on every write
  always_ff @(posedge CLK) begin
    if (i_enq) begin
      mem[0] <= i_din;
      for (int i = 1; i < DEPTH; i++) begin
        mem[i] <= mem[i-1];
      end
    end
  end

  assign o_dout  = mem[head];
  assign o_valid = (cnt != '0);
  assign o_full  = (cnt == DEPTH);

endmodule

// ==== logic/merge_node.sv ====
// two input merge node
// pops the smaller head key into a two entry result queue
// ties go to input 1 and merging waits for both inputs

`timescale 1ns/100ps

module merge_node (
  input  logic               CLK,
  input  logic               RST,
  input  sort_rec_pkg::rec_u i_rec0,
  input  logic               i_valid0,
  input  sort_rec_pkg::rec_u i_rec1,
  input  logic               i_valid1,
  output logic               o_deq0,
  output logic               o_deq1,
  input  logic               i_deq,     // pop from the consumer
  output sort_rec_pkg::rec_u o_rec,
  output logic               o_valid
);

  sort_rec_pkg::rec_u mem [2];
  sort_rec_pkg::rec_u win;
  logic               head;
  logic               tail;
  logic [1:0]         cnt;
  logic               lt;     // input 0 strictly smaller
  logic               enq;

  assign lt  = (i_rec0.f.key < i_rec1.f.key);
  assign enq = i_valid0 && i_valid1 && (cnt != 2'd2);
  assign win = lt ? i_rec0 : i_rec1;

  assign o_deq0 = enq && lt;
  assign o_deq1 = enq && !lt;

  // result queue control
  always_ff @(posedge CLK) begin
    if (RST) begin
      head <= 1'b0;
      tail <= 1'b0;
      cnt  <= 2'd0;
    end else begin
      case ({enq, i_deq})
        2'b10: begin
          tail <= ~tail;
          cnt  <= cnt + 2'd1;
        end
        2'b01: begin
          head <= ~head;
          cnt  <= cnt - 2'd1;
        end
        2'b11: begin
          head <= ~head;
          tail <= ~tail;
        end
        default: ;
      endcase
    end
  end

  always_ff @(posedge CLK) begin
    if (enq) begin
      mem[tail] <= win;
    end
  end

  assign o_rec   = mem[head];
  assign o_valid = (cnt != 2'd0);

endmodule

// ==== logic/rec_wr_if.sv ====
// record write channel into the lane bank
// full flags come back per lane

`timescale 1ns/100ps

interface rec_wr_if;

  sort_rec_pkg::rec_u                       rec;
  logic                                     wr_en;
  logic [sort_cfg_pkg::LANE_IDX_W-1:0]      lane;   // target lane
  logic [sort_cfg_pkg::NUM_LANES-1:0]       full;   // one flag per lane

  modport src (
    output rec, wr_en, lane,
    input  full
  );

  modport dst (
    input  rec, wr_en, lane,
    output full
  );

endinterface

// ==== logic/sort_cfg_pkg.sv ====
// merge sorter configuration
// record widths, lane count and default lane FIFO depth

package sort_cfg_pkg;

  parameter int KEY_W     = 32;  // sort key bits
  parameter int PAYLOAD_W = 32;  // payload carried with the key
  parameter int REC_W     = KEY_W + PAYLOAD_W;

  // input lanes with one ascending run each
  parameter int NUM_LANES  = 4;
  parameter int LANE_IDX_W = $clog2(NUM_LANES);

  // log2 of lane FIFO depth where 2 gives 4 entries
  parameter int FIFO_LOG_DEF = 2;

endpackage

// ==== logic/sort_output.sv ====
// output register of the sorter
// loads from the root node and holds while the consumer is full

`timescale 1ns/100ps

module sort_output (
  input  logic                              CLK,
  input  logic                              RST,
  input  sort_rec_pkg::rec_u                i_rec,
  input  logic                              i_valid,
  output logic                              o_deq,
  input  logic                              i_out_full,
  output logic [sort_cfg_pkg::REC_W-1:0]    o_dout,
  output logic                              o_dout_valid
);

  logic load;  // register empty or drained this cycle

  assign load  = !o_dout_valid || !i_out_full;
  assign o_deq = i_valid && load;

  always_ff @(posedge CLK) begin
    if (RST) begin
      o_dout_valid <= 1'b0;
    end else if (load) begin
      o_dout_valid <= i_valid;
    end
  end

  always_ff @(posedge CLK) begin
    if (load) begin
      o_dout <= i_rec.raw;
    end
  end

endmodule

// ==== logic/sort_rec_pkg.sv ====
// record layout for the merge sorter
// one word seen either raw or as payload and key

package sort_rec_pkg;

  // payload in the upper half and key in the lower half
  typedef struct packed {
    logic [sort_cfg_pkg::PAYLOAD_W-1:0] payload;
    logic [sort_cfg_pkg::KEY_W-1:0]     key;
  } rec_fields_t;

  // storage moves raw while the compare logic decodes f
  typedef union packed {
    logic [sort_cfg_pkg::REC_W-1:0] raw;
    rec_fields_t                    f;
  } rec_u;

  // end of run marker that sorts after every real key
  parameter logic [sort_cfg_pkg::KEY_W-1:0] KEY_MAX = '1;

endpackage

// ==== logic/sort_top.sv ====
// four way merge sorter
// lane bank feeds two merge nodes and a root node merges their streams
// into the back-pressured output register

`timescale 1ns/100ps

module sort_top #(
  parameter int FIFO_LOG = sort_cfg_pkg::FIFO_LOG_DEF
) (
  input  logic                                 CLK,
  input  logic                                 RST,
  input  logic [sort_cfg_pkg::REC_W-1:0]       i_din,
  input  logic                                 i_din_valid,
  input  logic [sort_cfg_pkg::LANE_IDX_W-1:0]  i_din_lane,
  output logic [sort_cfg_pkg::NUM_LANES-1:0]   o_lane_full,
  output logic [sort_cfg_pkg::REC_W-1:0]       o_dout,
  output logic                                 o_dout_valid,
  input  logic                                 i_out_full
);

  rec_wr_if wr ();

  sort_rec_pkg::rec_u [sort_cfg_pkg::NUM_LANES-1:0] lane_head;
  logic [sort_cfg_pkg::NUM_LANES-1:0]               lane_valid;
  logic [sort_cfg_pkg::NUM_LANES-1:0]               lane_deq;

  sort_rec_pkg::rec_u lo_rec, hi_rec, root_rec;
  logic               lo_valid, hi_valid, root_valid;
  logic               lo_deq, hi_deq, root_deq;

  assign wr.rec      = i_din;
  assign wr.wr_en    = i_din_valid;
  assign wr.lane     = i_din_lane;
  assign o_lane_full = wr.full;

  lane_bank #(
    .FIFO_LOG (FIFO_LOG)
  ) u_bank (
    .CLK          (CLK),
    .RST          (RST),
    .wr           (wr.dst),
    .i_deq        (lane_deq),
    .o_head       (lane_head),
    .o_head_valid (lane_valid)
  );

  // lanes 0 and 1
  merge_node node_lo (
    .CLK (CLK), .RST (RST),
    .i_rec0 (lane_head[0]), .i_valid0 (lane_valid[0]),
    .i_rec1 (lane_head[1]), .i_valid1 (lane_valid[1]),
    .o_deq0 (lane_deq[0]),  .o_deq1   (lane_deq[1]),
    .i_deq  (lo_deq),       .o_rec    (lo_rec),    .o_valid (lo_valid)
  );

  // lanes 2 and 3
  merge_node node_hi (
    .CLK (CLK), .RST (RST),
    .i_rec0 (lane_head[2]), .i_valid0 (lane_valid[2]),
    .i_rec1 (lane_head[3]), .i_valid1 (lane_valid[3]),
    .o_deq0 (lane_deq[2]),  .o_deq1   (lane_deq[3]),
    .i_deq  (hi_deq),       .o_rec    (hi_rec),    .o_valid (hi_valid)
  );

  merge_node node_root (
    .CLK (CLK), .RST (RST),
    .i_rec0 (lo_rec),   .i_valid0 (lo_valid),
    .i_rec1 (hi_rec),   .i_valid1 (hi_valid),
    .o_deq0 (lo_deq),   .o_deq1   (hi_deq),
    .i_deq  (root_deq), .o_rec    (root_rec),  .o_valid (root_valid)
  );

  sort_output u_out (
    .CLK          (CLK),
    .RST          (RST),
    .i_rec        (root_rec),
    .i_valid      (root_valid),
    .o_deq        (root_deq),
    .i_out_full   (i_out_full),
    .o_dout       (o_dout),
    .o_dout_valid (o_dout_valid)
  );

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the merge sorter testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_sort_top -f tb.f -o tb_sort_top

# a failed assertion can stop the run early, the printed lines decide
out=$(./obj_dir/tb_sort_top 2>&1) || true
echo "$out"
if grep -q "TEST PASSED" <<< "$out"; then
  exit 0
fi
exit 1

// ==== tb.f ====
logic/sort_cfg_pkg.sv
logic/sort_rec_pkg.sv
logic/rec_wr_if.sv
logic/lane_fifo.sv
logic/lane_bank.sv
logic/merge_node.sv
logic/sort_output.sv
logic/sort_top.sv
verif/sort_assert.sv
verif/tb_sort_top.sv

// ==== verif/sort_assert.sv ====
// port level checks for the merge sorter
// reset state, output key order, output hold under back-pressure

`timescale 1ns/100ps

module sort_assert (
  input logic                                CLK,
  input logic                                RST,
  input logic [sort_cfg_pkg::REC_W-1:0]      i_dout,
  input logic                                i_dout_valid,
  input logic                                i_out_full,
  input logic [sort_cfg_pkg::NUM_LANES-1:0]  i_lane_full
);

  sort_rec_pkg::rec_u              out_w;
  logic [sort_cfg_pkg::KEY_W-1:0]  last_key;
  logic                            seen;      // a real key has left already
  logic                            take;      // record consumed this cycle
  logic                            real_key;

  int fail_reset = 0;
  int fail_order = 0;
  int fail_hold  = 0;

  assign out_w    = i_dout;
  assign take     = i_dout_valid && !i_out_full;
  assign real_key = (out_w.f.key != sort_rec_pkg::KEY_MAX);

  always_ff @(posedge CLK) begin
    if (RST) begin
      seen     <= 1'b0;
      last_key <= '0;
    end else if (take && real_key) begin
      seen     <= 1'b1;
      last_key <= out_w.f.key;
    end
  end

  a_reset_state: assert property (@(posedge CLK)
    $past(RST) |-> (!i_dout_valid && i_lane_full == '0))
    else begin
      $error("output valid or a lane full flag set right after reset");
      fail_reset++;
    end

  // terminators are left out of the order
  a_key_order: assert property (@(posedge CLK) disable iff (RST)
    (take && real_key && seen) |-> (out_w.f.key >= last_key))
    else begin
      $error("output key %0h below previous key %0h", out_w.f.key, last_key);
      fail_order++;
    end

  a_hold: assert property (@(posedge CLK) disable iff (RST)
    (i_dout_valid && i_out_full) |=> (i_dout_valid && i_dout == $past(i_dout)))
    else begin
      $error("output record changed while the consumer was full");
      fail_hold++;
    end

endmodule

bind sort_top sort_assert u_assert (
  .CLK          (CLK),
  .RST          (RST),
  .i_dout       (o_dout),
  .i_dout_valid (o_dout_valid),
  .i_out_full   (i_out_full),
  .i_lane_full  (o_lane_full)
);

// ==== verif/tb_sort_top.sv ====
// testbench for the four way merge sorter
// ascending random runs per lane, one write into a full lane,
// random output back-pressure, count and key sum check at the end

`timescale 1ns/100ps

module tb_sort_top;

  localparam int FIFO_LOG = sort_cfg_pkg::FIFO_LOG_DEF;
  localparam int LANES    = sort_cfg_pkg::NUM_LANES;
  localparam int RUN_LEN  = 4;     // three keys plus terminator
  localparam int LIMIT    = 2000;  // cycles allowed per wait

  logic                                 CLK = 1'b0;
  logic                                 RST;
  logic [sort_cfg_pkg::REC_W-1:0]       i_din;
  logic                                 i_din_valid;
  logic [sort_cfg_pkg::LANE_IDX_W-1:0]  i_din_lane;
  logic [LANES-1:0]                     o_lane_full;
  logic [sort_cfg_pkg::REC_W-1:0]       o_dout;
  logic                                 o_dout_valid;
  logic                                 i_out_full;

  integer             seed      = 32'h756a;
  int                 errors    = 0;
  int                 drop_errs = 0;  // dropped record seen at the output
  bit                 timed_out = 1'b0;
  int                 exp_cnt   = 0;
  int                 out_cnt   = 0;
  int                 term_cnt  = 0;
  logic [63:0]        exp_sum   = '0;
  logic [63:0]        out_sum   = '0;
  sort_rec_pkg::rec_u runs [LANES][RUN_LEN];
  sort_rec_pkg::rec_u dropped;
  sort_rec_pkg::rec_u got;

  sort_top #(
    .FIFO_LOG (FIFO_LOG)
  ) i_dut (
    .CLK          (CLK),
    .RST          (RST),
    .i_din        (i_din),
    .i_din_valid  (i_din_valid),
    .i_din_lane   (i_din_lane),
    .o_lane_full  (o_lane_full),
    .o_dout       (o_dout),
    .o_dout_valid (o_dout_valid),
    .i_out_full   (i_out_full)
  );

  always #5 CLK = ~CLK;

  // a record leaves when valid and the consumer is not full
  always @(posedge CLK) begin
    got = o_dout;
    if (!RST && o_dout_valid && !i_out_full) begin
      if (got.raw == dropped.raw) begin
        $display("record %h written to a full lane reached the output at %0t", got.raw, $time);
        drop_errs++;
      end
      if (got.f.key == sort_rec_pkg::KEY_MAX) begin
        term_cnt++;
      end else begin
        out_cnt++;
        out_sum = out_sum + 64'(got.f.key);
      end
    end
  end

  task automatic build_runs();
    logic [sort_cfg_pkg::KEY_W-1:0] k;
    for (int l = 0; l < LANES; l++) begin
      k = $random(seed) & 32'h0000_0fff;
      for (int i = 0; i < RUN_LEN - 1; i++) begin
        runs[l][i].f.key     = k;
        runs[l][i].f.payload = 32'(l * 16 + i);
        k = k + ($random(seed) & 32'h0000_00ff);  // equal keys allowed
      end
      runs[l][RUN_LEN-1].f.key     = sort_rec_pkg::KEY_MAX;
      runs[l][RUN_LEN-1].f.payload = 32'(l);
    end
  endtask

  // drops the write strobe and picks new back-pressure on the falling edge
  task automatic next_cycle();
    @(negedge CLK);
    i_din_valid = 1'b0;
    i_out_full  = (($random(seed) & 32'h3) == 32'h0);
  endtask

  task automatic wait_not_full(input int lane);
    int t;
    t = 0;
    while (o_lane_full[lane] && !timed_out) begin
      next_cycle();
      t++;
      if (t >= LIMIT) begin
        $display("timeout at %0t: lane %0d stayed full", $time, lane);
        errors++;
        timed_out = 1'b1;
      end
    end
  endtask

  task automatic write_rec(input int lane, input sort_rec_pkg::rec_u rec);
    next_cycle();
    wait_not_full(lane);
    if (!timed_out) begin
      i_din       = rec.raw;
      i_din_lane  = sort_cfg_pkg::LANE_IDX_W'(lane);
      i_din_valid = 1'b1;
      if (rec.f.key != sort_rec_pkg::KEY_MAX) begin
        exp_cnt++;
        exp_sum = exp_sum + 64'(rec.f.key);
      end
    end
  endtask

  // all real keys plus the one terminator that gets through the root
  task automatic wait_outputs();
    int t;
    t = 0;
    while (!(out_cnt == exp_cnt && term_cnt == 1) && !timed_out) begin
      next_cycle();
      t++;
      if (t >= LIMIT) begin
        $display("timeout at %0t: got %0d records and %0d terminators", $time, out_cnt, term_cnt);
        errors++;
        timed_out = 1'b1;
      end
    end
  endtask

  task automatic finish_run();
    int assert_errs;
    assert_errs = i_dut.u_assert.fail_reset + i_dut.u_assert.fail_order
                + i_dut.u_assert.fail_hold;
    $display("errors: checks %0d, dropped %0d, assertions %0d", errors, drop_errs, assert_errs);
    if (errors + drop_errs + assert_errs == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  endtask

  initial begin
    RST         = 1'b1;
    i_din       = '0;
    i_din_valid = 1'b0;
    i_din_lane  = '0;
    i_out_full  = 1'b0;
    build_runs();
    dropped.f.payload = 32'hffff_0000;
    dropped.f.key     = runs[0][1].f.key;
    repeat (10) @(posedge CLK);
    @(negedge CLK);
    RST = 1'b0;

    // lane 0 alone so its merge node cannot pop yet
    for (int i = 0; i < RUN_LEN; i++) begin
      write_rec(0, runs[0][i]);
    end
    next_cycle();
    if (RUN_LEN >= (1 << FIFO_LOG) && !o_lane_full[0]) begin
      $display("mismatch at %0t: o_lane_full[0] got %0b expected 1", $time, o_lane_full[0]);
      errors++;
    end
    i_din       = dropped.raw;  // must be discarded
    i_din_lane  = '0;
    i_din_valid = 1'b1;

    for (int i = 0; i < RUN_LEN; i++) begin
      for (int l = 1; l < LANES; l++) begin
        write_rec(l, runs[l][i]);
      end
    end
    wait_outputs();
    repeat (20) next_cycle();  // room for stray records

    if (!timed_out && out_cnt != exp_cnt) begin
      $display("mismatch at %0t: key_count got %0d expected %0d", $time, out_cnt, exp_cnt);
      errors++;
    end
    if (!timed_out && out_sum != exp_sum) begin
      $display("mismatch at %0t: key_sum got %0d expected %0d", $time, out_sum, exp_sum);
      errors++;
    end
    finish_run();
  end

endmodule
